//--- rob_pkg.sv
package rob_pkg;

   localparam int unsigned ROB_ENTRIES = 128;
   localparam int unsigned SLOTS = 4;   // dispatch width

   typedef logic [$clog2(ROB_ENTRIES)-1:0] rob_idx_t;   // wraps at 128

   typedef logic [2:0] cnt_t;   // 0 to 4

   // one decoded instruction of 66 bits
   typedef struct packed {
      logic [38:0] payload_hi;   // 65:27
      logic        is_load;      // 26
      logic        is_store;     // 25
      logic [24:0] payload_lo;   // 24:0
   } inst_t;

   typedef struct packed {
      inst_t [SLOTS-1:0] inst;    // slot 0 in low word
      logic  [SLOTS-1:0] valid;   // per-slot valid
   } bundle_t;

   typedef struct packed {
      logic     valid;
      rob_idx_t idx;
   } lsq_slot_t;

   typedef lsq_slot_t [SLOTS-1:0] slot_vec_t;   // position 0 in low byte

endpackage

//--- dispatch_stage.sv
`timescale 1ns/1ns

module dispatch_stage (
   input  logic             clk,
   input  logic             arst_n,
   input  rob_pkg::bundle_t bundle,
   input  logic             in_valid,
   output logic             in_ready,
   input  logic             stall,
   output rob_pkg::bundle_t held,
   output logic             held_valid
);

   logic fire;
   logic accept;
   logic out_of_reset;   // keeps in_ready low through reset

   assign fire     = held_valid && !stall;
   assign in_ready = out_of_reset && (!held_valid || fire);
   assign accept   = in_valid && in_ready;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         held_valid   <= 1'b0;
         out_of_reset <= 1'b0;
      end else begin
         out_of_reset <= 1'b1;
         if (accept) begin
            held_valid <= 1'b1;   // replaces a firing bundle too
         end else if (fire) begin
            held_valid <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         held <= bundle;
      end
   end

endmodule

//--- rob_tail_alloc.sv
`timescale 1ns/1ns

module rob_tail_alloc #(
   parameter int LSQ_DEPTH = 16
) (
   input  logic                       clk,
   input  logic                       arst_n,
   input  rob_pkg::bundle_t           held,
   input  logic                       held_valid,
   input  logic [$clog2(LSQ_DEPTH):0] ld_free,
   input  logic [$clog2(LSQ_DEPTH):0] st_free,
   input  rob_pkg::cnt_t              retire_cnt,
   output rob_pkg::rob_idx_t          tail,
   output logic                       stall
);

   localparam int FW  = $clog2(LSQ_DEPTH) + 1;
   localparam int RFW = $clog2(rob_pkg::ROB_ENTRIES) + 1;

   rob_pkg::cnt_t  ld_cnt;
   rob_pkg::cnt_t  st_cnt;
   logic [RFW-1:0] rob_free;   // 0 to 128
   logic           fire;

   always_comb begin
      ld_cnt = '0;
      st_cnt = '0;
      for (int k = 0; k < rob_pkg::SLOTS; k++) begin
         if (held.valid[k] && held.inst[k].is_load) ld_cnt = ld_cnt + 3'd1;
         if (held.valid[k] && held.inst[k].is_store) st_cnt = st_cnt + 3'd1;
      end
   end

   // every slot reserves an entry, valid or not
   assign stall = !held_valid
                  || (rob_free < RFW'(rob_pkg::SLOTS))
                  || (ld_free < FW'(ld_cnt))
                  || (st_free < FW'(st_cnt));
   assign fire  = !stall;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         tail     <= '0;
         rob_free <= RFW'(rob_pkg::ROB_ENTRIES);
      end else begin
         if (fire) begin
            tail <= tail + rob_pkg::rob_idx_t'(rob_pkg::SLOTS);   // wraps mod 128
         end
         rob_free <= rob_free - (fire ? RFW'(rob_pkg::SLOTS) : '0) + RFW'(retire_cnt);
      end
   end

endmodule

//--- reorder_unit.sv
`timescale 1ns/1ns

module reorder_unit (
   input  rob_pkg::bundle_t   held,
   input  rob_pkg::rob_idx_t  tail,
   input  logic               stall,
   output rob_pkg::slot_vec_t ld_slots,
   output rob_pkg::slot_vec_t st_slots
);

   rob_pkg::rob_idx_t slot_idx [rob_pkg::SLOTS];

   always_comb begin
      for (int k = 0; k < rob_pkg::SLOTS; k++) begin
         slot_idx[k] = tail + rob_pkg::rob_idx_t'(k);
      end
   end

   // priority compaction with the lowest slot in position 0
   always_comb begin : compact
      logic [2:0] ld_pos;
      logic [2:0] st_pos;
      ld_pos   = '0;
      st_pos   = '0;
      ld_slots = '0;
      st_slots = '0;
      for (int k = 0; k < rob_pkg::SLOTS; k++) begin
         if (held.valid[k] && held.inst[k].is_load) begin
            ld_slots[ld_pos[1:0]].valid = !stall;
            ld_slots[ld_pos[1:0]].idx   = slot_idx[k];
            ld_pos = ld_pos + 3'd1;
         end
         if (held.valid[k] && held.inst[k].is_store) begin
            st_slots[st_pos[1:0]].valid = !stall;
            st_slots[st_pos[1:0]].idx   = slot_idx[k];
            st_pos = st_pos + 3'd1;
         end
      end
   end

endmodule

//--- lsq_alloc_queue.sv
`timescale 1ns/1ns

module lsq_alloc_queue #(
   parameter int LSQ_DEPTH = 16
) (
   input  logic                       clk,
   input  logic                       arst_n,
   input  rob_pkg::slot_vec_t         slots,
   input  logic                       pop,
   output rob_pkg::rob_idx_t          head,
   output logic                       head_valid,
   output logic [$clog2(LSQ_DEPTH):0] free_cnt
);

   localparam int AW = $clog2(LSQ_DEPTH);
   localparam int CW = AW + 1;

   rob_pkg::rob_idx_t mem [LSQ_DEPTH];
   logic [AW-1:0]     wr_ptr;
   logic [AW-1:0]     rd_ptr;
   logic [CW-1:0]     count;
   logic [AW-1:0]     wr_addr [rob_pkg::SLOTS];
   rob_pkg::cnt_t     push_cnt;
   logic              pop_ok;

   // consecutive write addresses for the valid positions
   always_comb begin
      push_cnt = '0;
      for (int j = 0; j < rob_pkg::SLOTS; j++) begin
         wr_addr[j] = wr_ptr + AW'(push_cnt);
         if (slots[j].valid) push_cnt = push_cnt + 3'd1;
      end
   end

   assign head_valid = (count != '0);
   assign head       = mem[rd_ptr];
   assign pop_ok     = pop && head_valid;   // pop on empty is dropped
   assign free_cnt   = CW'(LSQ_DEPTH) - count;

   always_ff @(posedge clk) begin
      for (int j = 0; j < rob_pkg::SLOTS; j++) begin
         if (slots[j].valid) begin
            mem[wr_addr[j]] <= slots[j].idx;
         end
      end
   end

   // upstream stall keeps pushes within the free entries
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         wr_ptr <= wr_ptr + AW'(push_cnt);
         rd_ptr <= rd_ptr + AW'(pop_ok);
         count  <= count + CW'(push_cnt) - CW'(pop_ok);
      end
   end

endmodule

//--- rob_dispatch_top.sv
`timescale 1ns/1ns

module rob_dispatch_top #(
   parameter int LSQ_DEPTH = 16
) (
   input  logic              clk,
   input  logic              arst_n,
   input  rob_pkg::bundle_t  bundle,
   input  logic              in_valid,
   output logic              in_ready,
   input  rob_pkg::cnt_t     retire_cnt,
   output rob_pkg::rob_idx_t ld_idx,
   output logic              ld_valid,
   input  logic              ld_pop,
   output rob_pkg::rob_idx_t st_idx,
   output logic              st_valid,
   input  logic              st_pop
);

   localparam int FW = $clog2(LSQ_DEPTH) + 1;

   rob_pkg::bundle_t   held;
   logic               held_valid;
   logic               stall;
   rob_pkg::rob_idx_t  tail;
   rob_pkg::slot_vec_t ld_slots;
   rob_pkg::slot_vec_t st_slots;
   logic [FW-1:0]      ld_free;
   logic [FW-1:0]      st_free;

   dispatch_stage i_dispatch_stage (
      .clk        (clk),
      .arst_n     (arst_n),
      .bundle     (bundle),
      .in_valid   (in_valid),
      .in_ready   (in_ready),
      .stall      (stall),
      .held       (held),
      .held_valid (held_valid)
   );

   rob_tail_alloc #(.LSQ_DEPTH(LSQ_DEPTH)) i_rob_tail_alloc (
      .clk        (clk),
      .arst_n     (arst_n),
      .held       (held),
      .held_valid (held_valid),
      .ld_free    (ld_free),
      .st_free    (st_free),
      .retire_cnt (retire_cnt),
      .tail       (tail),
      .stall      (stall)
   );

   reorder_unit i_reorder_unit (
      .held     (held),
      .tail     (tail),
      .stall    (stall),
      .ld_slots (ld_slots),
      .st_slots (st_slots)
   );

   lsq_alloc_queue #(.LSQ_DEPTH(LSQ_DEPTH)) i_ld_queue (
      .clk        (clk),
      .arst_n     (arst_n),
      .slots      (ld_slots),
      .pop        (ld_pop),
      .head       (ld_idx),
      .head_valid (ld_valid),
      .free_cnt   (ld_free)
   );

   lsq_alloc_queue #(.LSQ_DEPTH(LSQ_DEPTH)) i_st_queue (
      .clk        (clk),
      .arst_n     (arst_n),
      .slots      (st_slots),
      .pop        (st_pop),
      .head       (st_idx),
      .head_valid (st_valid),
      .free_cnt   (st_free)
   );

endmodule

//--- tb_rob_dispatch_asserts.sv
`timescale 1ns/1ns

module tb_rob_dispatch_asserts (
   input logic                                   clk,
   input logic                                   arst_n,
   input logic [$clog2(rob_pkg::ROB_ENTRIES):0]  rob_free,
   input logic                                   held_valid,
   input logic                                   in_ready,
   input logic                                   ld_valid,
   input logic                                   st_valid
);

   int fail_cnt = 0;   // polled by the testbench

   a_rob_free_max: assert property (@(posedge clk) disable iff (!arst_n)
      rob_free <= 128)
      else begin
         $error("rob free count above 128: %0d", rob_free);
         fail_cnt++;
      end

   // a held bundle facing a full rob must block new bundles
   a_no_ready_on_stall: assert property (@(posedge clk) disable iff (!arst_n)
      (held_valid && (rob_free < 4)) |-> !in_ready)
      else begin
         $error("in_ready high while held bundle waits on a full ROB");
         fail_cnt++;
      end

   a_valid_known: assert property (@(posedge clk) disable iff (!arst_n)
      !$isunknown({ld_valid, st_valid}))
      else begin
         $error("ld_valid or st_valid unknown");
         fail_cnt++;
      end

endmodule

bind rob_dispatch_top tb_rob_dispatch_asserts i_asserts (
   .clk        (clk),
   .arst_n     (arst_n),
   .rob_free   (i_rob_tail_alloc.rob_free),
   .held_valid (held_valid),
   .in_ready   (in_ready),
   .ld_valid   (ld_valid),
   .st_valid   (st_valid)
);

//--- tb_rob_dispatch.sv
`timescale 1ns/1ns

module tb_rob_dispatch;

   localparam int LSQ_DEPTH  = 16;
   localparam int N_BUNDLES  = 2 + 200 + 20 + 400 + 120 + 80;   // one offer per cycle
   localparam int TIMEOUT_NS = N_BUNDLES * 40 * 40 + 20000;

   typedef logic [$clog2(LSQ_DEPTH):0] occ_t;   // same width as free_cnt

   logic clk;
   logic arst_n;
   rob_pkg::bundle_t  bundle;
   logic              in_valid;
   logic              in_ready;
   rob_pkg::cnt_t     retire_cnt;
   rob_pkg::rob_idx_t ld_idx;
   logic              ld_valid;
   logic              ld_pop;
   rob_pkg::rob_idx_t st_idx;
   logic              st_valid;
   logic              st_pop;

   logic [31:0]       lfsr_state = 32'd96755;
   rob_pkg::bundle_t  m_held;
   logic              m_held_valid;
   logic              m_in_ready;
   rob_pkg::rob_idx_t m_tail;
   int                m_rob_free;
   int                fire_cnt;
   rob_pkg::rob_idx_t ld_q [$];
   rob_pkg::rob_idx_t st_q [$];

   rob_dispatch_top #(.LSQ_DEPTH(LSQ_DEPTH)) i_rob_dispatch_top (
      .clk        (clk),
      .arst_n     (arst_n),
      .bundle     (bundle),
      .in_valid   (in_valid),
      .in_ready   (in_ready),
      .retire_cnt (retire_cnt),
      .ld_idx     (ld_idx),
      .ld_valid   (ld_valid),
      .ld_pop     (ld_pop),
      .st_idx     (st_idx),
      .st_valid   (st_valid),
      .st_pop     (st_pop)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   initial begin
      #(TIMEOUT_NS);
      fail_stop("timeout, the run did not finish in time");
   end

   task automatic fail_stop(input string msg);
      $display("%s", msg);
      $display("Finished with errors");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_idx(input string name, input rob_pkg::rob_idx_t got,
                            input rob_pkg::rob_idx_t exp);
      if (got !== exp) fail_stop($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) fail_stop($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
   endtask

   task automatic check_count(input string name, input occ_t got, input occ_t exp);
      if (got !== exp) fail_stop($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
   endtask

   // galois lfsr stepped once per bit taken
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
   endfunction

   task automatic draw_bits(input int n, output logic [63:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         v[i] = lfsr_state[0];
         lfsr_state = lfsr_step(lfsr_state);
      end
   endtask

   task automatic reset_model();
      m_held       = '0;
      m_held_valid = 1'b0;
      m_in_ready   = 1'b0;
      m_tail       = '0;
      m_rob_free   = 128;
      fire_cnt     = 0;
      ld_q.delete();
      st_q.delete();
   endtask

   function automatic logic predict_stall();
      int ldc = 0;
      int stc = 0;
      for (int k = 0; k < 4; k++) begin
         if (m_held.valid[k] && m_held.inst[k].is_load) ldc++;
         if (m_held.valid[k] && m_held.inst[k].is_store) stc++;
      end
      return !m_held_valid || (m_rob_free < 4)
             || ((LSQ_DEPTH - ld_q.size()) < ldc) || ((LSQ_DEPTH - st_q.size()) < stc);
   endfunction

   // state after the coming rising edge
   task automatic advance_model();
      logic fire;
      logic accept;
      fire   = !predict_stall();
      accept = in_valid && m_in_ready;
      if (ld_pop && ld_q.size() > 0) void'(ld_q.pop_front());
      if (st_pop && st_q.size() > 0) void'(st_q.pop_front());
      if (fire) begin
         for (int k = 0; k < 4; k++) begin
            if (m_held.valid[k] && m_held.inst[k].is_load) begin
               ld_q.push_back(m_tail + rob_pkg::rob_idx_t'(k));
            end
            if (m_held.valid[k] && m_held.inst[k].is_store) begin
               st_q.push_back(m_tail + rob_pkg::rob_idx_t'(k));
            end
         end
         m_tail     = m_tail + 7'd4;   // wraps at 128
         m_rob_free = m_rob_free - 4;
         fire_cnt++;
      end
      m_rob_free = m_rob_free + int'(retire_cnt);
      if (accept) begin
         m_held       = bundle;
         m_held_valid = 1'b1;
      end else if (fire) begin
         m_held_valid = 1'b0;
      end
      m_in_ready = !m_held_valid || !predict_stall();
   endtask

   // mode 0 is low, 1 is high and 2 is random
   task automatic drive_inputs(input int valid_mode, input bit retire_on,
                               input int ld_mode, input int st_mode);
      logic [63:0]      r;
      rob_pkg::bundle_t b;
      int               lim;
      if (!(in_valid && !m_in_ready)) begin   // a waiting bundle stays put
         draw_bits(1, r);
         in_valid = (valid_mode == 2) ? r[0] : (valid_mode == 1);
         for (int k = 0; k < 4; k++) begin
            draw_bits(1, r);
            b.valid[k] = r[0];
            draw_bits(2, r);
            b.inst[k].is_load  = (r[1:0] == 2'd1);
            b.inst[k].is_store = (r[1:0] == 2'd2);
            draw_bits(39, r);
            b.inst[k].payload_hi = r[38:0];
            draw_bits(25, r);
            b.inst[k].payload_lo = r[24:0];
         end
         bundle = b;
      end
      retire_cnt = '0;
      if (retire_on) begin
         draw_bits(3, r);
         lim = (128 - m_rob_free < 4) ? 128 - m_rob_free : 4;
         retire_cnt = (int'(r[2:0]) > lim) ? rob_pkg::cnt_t'(lim) : r[2:0];
      end
      draw_bits(1, r);
      ld_pop = (ld_mode == 2) ? r[0] : (ld_mode == 1);
      draw_bits(1, r);
      st_pop = (st_mode == 2) ? r[0] : (st_mode == 1);
   endtask

   task automatic compare_outputs();
      if (i_rob_dispatch_top.i_asserts.fail_cnt != 0) fail_stop("a bound assertion failed");
      check_flag("in_ready", in_ready, m_in_ready);
      check_flag("ld_valid", ld_valid, ld_q.size() != 0);
      check_flag("st_valid", st_valid, st_q.size() != 0);
      if (ld_q.size() != 0) check_idx("ld_idx", ld_idx, ld_q[0]);
      if (st_q.size() != 0) check_idx("st_idx", st_idx, st_q[0]);
      check_count("ld_occupancy", occ_t'(LSQ_DEPTH) - i_rob_dispatch_top.ld_free,
                  occ_t'(ld_q.size()));
      check_count("st_occupancy", occ_t'(LSQ_DEPTH) - i_rob_dispatch_top.st_free,
                  occ_t'(st_q.size()));
   endtask

   task automatic run_phase(input int cycles, input int valid_mode, input bit retire_on,
                            input int ld_mode, input int st_mode);
      for (int c = 0; c < cycles; c++) begin
         compare_outputs();
         drive_inputs(valid_mode, retire_on, ld_mode, st_mode);
         advance_model();
         @(negedge clk);
      end
   endtask

   initial begin : main
      arst_n     = 1'b0;
      bundle     = '0;
      in_valid   = 1'b0;
      retire_cnt = '0;
      ld_pop     = 1'b0;
      st_pop     = 1'b0;
      reset_model();
      repeat (2) begin
         @(negedge clk);
         check_flag("in_ready", in_ready, 1'b0);
         check_flag("ld_valid", ld_valid, 1'b0);
         check_flag("st_valid", st_valid, 1'b0);
      end
      arst_n = 1'b1;

      run_phase(200, 1, 1'b0, 1, 1);   // fill the rob with no retire
      if (fire_cnt != 32) fail_stop("the ROB did not stop after exactly 32 bundles");
      run_phase(20, 1, 1'b0, 1, 1);
      if (fire_cnt != 32) fail_stop("a bundle fired while the ROB was full");
      run_phase(400, 2, 1'b1, 2, 2);   // random traffic over tail wraps
      run_phase(120, 1, 1'b1, 0, 0);   // queues back up
      if (ld_q.size() <= LSQ_DEPTH - 4 && st_q.size() <= LSQ_DEPTH - 4)
         fail_stop("neither queue filled while pops were held low");
      run_phase(80, 0, 1'b1, 1, 1);    // drain
      if (ld_q.size() != 0 || st_q.size() != 0 || m_held_valid)
         fail_stop("the queues did not drain at the end");

      if (i_rob_dispatch_top.i_asserts.fail_cnt == 0) begin
         $display("Finished with no errors");
         $finish;
      end else begin
         fail_stop("bound assertions reported errors");
      end
   end

endmodule

//--- verilog.f
rob_pkg.sv
dispatch_stage.sv
rob_tail_alloc.sv
reorder_unit.sv
lsq_alloc_queue.sv
rob_dispatch_top.sv
tb_rob_dispatch_asserts.sv
tb_rob_dispatch.sv

//--- build.sh
#!/bin/sh
# compile and run the rob dispatch testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_rob_dispatch -f verilog.f -o tb_rob_dispatch
if [ $? -ne 0 ]; then
   echo "build.sh: verilator compile failed"
   exit 1
fi

./obj_dir/tb_rob_dispatch +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "build.sh: simulation exited with status $status"
   exit 1
fi

if grep -q "Finished with errors" "$LOG"; then
   echo "build.sh: simulation reported failure"
   exit 1
fi

echo "build.sh: simulation passed"
exit 0
